/* rtl/wb_dbus_pkg.sv */
`default_nettype none

package wb_dbus_pkg;

   localparam int ADR_W   = 32;
   localparam int DAT_W   = 32;
   localparam int MATCH_W = 4;

   // Address map, top MATCH_W bits of the address
   localparam logic [MATCH_W-1:0] SRAM_BASE = 4'h0;
   localparam logic [MATCH_W-1:0] EXT_BASE  = 4'h9;
   localparam logic [MATCH_W-1:0] CTRL_BASE = 4'hF;

   // 1024 words, window aliases every 4 KB
   localparam int SRAM_AW = 10;

   // Control register byte offsets
   localparam logic [3:0] REG_WDOG    = 4'h0;
   localparam logic [3:0] REG_ERRCNT  = 4'h4;
   localparam logic [3:0] REG_LASTERR = 4'h8;

   localparam logic [15:0] WDOG_LIMIT_RST = 16'd64;

   typedef struct packed {
      logic [ADR_W-1:0]   adr;
      logic [DAT_W-1:0]   dat;
      logic [DAT_W/8-1:0] sel;
      logic               we;
      logic               cyc;
      logic               stb;
      logic [2:0]         cti;
      logic [1:0]         bte;
   } wb_req_t;

   typedef struct packed {
      logic [DAT_W-1:0] dat;
      logic             ack;
      logic             err;
      logic             rty;
   } wb_rsp_t;

   // Target of the cycle in progress
   typedef enum logic [2:0] {
      TGT_NONE,
      TGT_SRAM,
      TGT_EXT,
      TGT_CTRL,
      TGT_BAD
   } tgt_t;

endpackage

`default_nettype wire

/* rtl/wb_master_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_master_arbiter (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_dbus_pkg::wb_req_t cpu_req_i,
   input  wb_dbus_pkg::wb_req_t dbg_req_i,
   output wb_dbus_pkg::wb_rsp_t cpu_rsp_o,
   output wb_dbus_pkg::wb_rsp_t dbg_rsp_o,
   output wb_dbus_pkg::wb_req_t bus_req_o,
   input  wb_dbus_pkg::wb_rsp_t bus_rsp_i
);

   typedef enum logic [1:0] {
      GNT_IDLE,
      GNT_CPU,
      GNT_DBG
   } gnt_t;

   gnt_t gnt_q;
   gnt_t gnt;

   // Debug wins only when the bus is idle
   always_comb begin
      gnt = gnt_q;
      if (gnt_q == GNT_IDLE) begin
         if (dbg_req_i.cyc) begin
            gnt = GNT_DBG;
         end else if (cpu_req_i.cyc) begin
            gnt = GNT_CPU;
         end
      end
   end

   // Held until the owner drops cyc
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         gnt_q <= GNT_IDLE;
      end else begin
         case (gnt_q)
            GNT_IDLE: gnt_q <= gnt;
            GNT_CPU: begin
               if (!cpu_req_i.cyc) begin
                  gnt_q <= GNT_IDLE;
               end
            end
            GNT_DBG: begin
               if (!dbg_req_i.cyc) begin
                  gnt_q <= GNT_IDLE;
               end
            end
            default: gnt_q <= GNT_IDLE;
         endcase
      end
   end

   always_comb begin
      case (gnt)
         GNT_CPU: bus_req_o = cpu_req_i;
         GNT_DBG: bus_req_o = dbg_req_i;
         default: bus_req_o = '0;
      endcase
   end

   // Read data is shared, handshakes go to the owner only
   always_comb begin
      cpu_rsp_o     = bus_rsp_i;
      dbg_rsp_o     = bus_rsp_i;
      cpu_rsp_o.ack = bus_rsp_i.ack & (gnt == GNT_CPU);
      cpu_rsp_o.err = bus_rsp_i.err & (gnt == GNT_CPU);
      cpu_rsp_o.rty = bus_rsp_i.rty & (gnt == GNT_CPU);
      dbg_rsp_o.ack = bus_rsp_i.ack & (gnt == GNT_DBG);
      dbg_rsp_o.err = bus_rsp_i.err & (gnt == GNT_DBG);
      dbg_rsp_o.rty = bus_rsp_i.rty & (gnt == GNT_DBG);
   end

   // No preemption of a granted cycle
   a_grant_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (gnt_q != GNT_IDLE && bus_req_o.cyc) |=> (gnt_q == $past(gnt_q)));

endmodule

`default_nettype wire

/* rtl/wb_slave_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_slave_decoder (
   input  logic                             wb_clk,
   input  logic                             wb_rst,
   input  wb_dbus_pkg::wb_req_t             bus_req_i,
   output wb_dbus_pkg::wb_rsp_t             bus_rsp_o,
   output wb_dbus_pkg::wb_req_t             sram_req_o,
   output wb_dbus_pkg::wb_req_t             ctrl_req_o,
   output wb_dbus_pkg::wb_req_t             ext_req_o,
   input  wb_dbus_pkg::wb_rsp_t             sram_rsp_i,
   input  wb_dbus_pkg::wb_rsp_t             ctrl_rsp_i,
   input  wb_dbus_pkg::wb_rsp_t             ext_rsp_i,
   input  logic                             wdog_abort_i,
   output logic                             decode_err_o,
   output logic [wb_dbus_pkg::ADR_W-1:0]    err_adr_o
);

   wb_dbus_pkg::tgt_t                  tgt_q;
   wb_dbus_pkg::tgt_t                  tgt_dec;
   logic [wb_dbus_pkg::MATCH_W-1:0]    match;
   logic [wb_dbus_pkg::ADR_W-1:0]      adr_q;
   logic                               strobe;
   logic                               strobe_d;
   logic                               fwd_q;
   logic                               done;
   logic                               bad_err;

   assign strobe = bus_req_i.cyc & bus_req_i.stb;
   assign match  = bus_req_i.adr[wb_dbus_pkg::ADR_W-1 -: wb_dbus_pkg::MATCH_W];
   assign done   = bus_rsp_o.ack | bus_rsp_o.err;

   always_comb begin
      case (match)
         wb_dbus_pkg::SRAM_BASE: tgt_dec = wb_dbus_pkg::TGT_SRAM;
         wb_dbus_pkg::EXT_BASE:  tgt_dec = wb_dbus_pkg::TGT_EXT;
         wb_dbus_pkg::CTRL_BASE: tgt_dec = wb_dbus_pkg::TGT_CTRL;
         default:                tgt_dec = wb_dbus_pkg::TGT_BAD;
      endcase
   end

   // Target is registered so responses never feed back into the select
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         strobe_d <= 1'b0;
         tgt_q    <= wb_dbus_pkg::TGT_NONE;
         fwd_q    <= 1'b0;
      end else begin
         strobe_d <= strobe;
         if (done || !strobe) begin
            tgt_q <= wb_dbus_pkg::TGT_NONE;
            fwd_q <= 1'b0;
         end else begin
            if (!strobe_d) begin
               tgt_q <= tgt_dec;
            end
            fwd_q <= (tgt_q != wb_dbus_pkg::TGT_NONE);
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (strobe && !strobe_d) begin
         adr_q <= bus_req_i.adr;
      end
   end

   // Everything but cyc and stb is broadcast
   always_comb begin
      sram_req_o     = bus_req_i;
      ctrl_req_o     = bus_req_i;
      ext_req_o      = bus_req_i;
      sram_req_o.cyc = bus_req_i.cyc & (tgt_q == wb_dbus_pkg::TGT_SRAM);
      ctrl_req_o.cyc = bus_req_i.cyc & (tgt_q == wb_dbus_pkg::TGT_CTRL);
      ext_req_o.cyc  = bus_req_i.cyc & (tgt_q == wb_dbus_pkg::TGT_EXT);
      sram_req_o.stb = fwd_q & strobe & (tgt_q == wb_dbus_pkg::TGT_SRAM);
      ctrl_req_o.stb = fwd_q & strobe & (tgt_q == wb_dbus_pkg::TGT_CTRL);
      ext_req_o.stb  = fwd_q & strobe & (tgt_q == wb_dbus_pkg::TGT_EXT) & ~wdog_abort_i;
   end

   // Default slave answers unmapped cycles
   assign bad_err = fwd_q & (tgt_q == wb_dbus_pkg::TGT_BAD);

   always_comb begin
      bus_rsp_o = '0;
      case (tgt_q)
         wb_dbus_pkg::TGT_SRAM: bus_rsp_o = sram_rsp_i;
         wb_dbus_pkg::TGT_CTRL: bus_rsp_o = ctrl_rsp_i;
         wb_dbus_pkg::TGT_EXT:  bus_rsp_o = ext_rsp_i;
         wb_dbus_pkg::TGT_BAD:  bus_rsp_o.err = bad_err;
         default:               bus_rsp_o = '0;
      endcase
      bus_rsp_o.rty = 1'b0;
      if (wdog_abort_i && tgt_q != wb_dbus_pkg::TGT_NONE) begin
         bus_rsp_o.ack = 1'b0;
         bus_rsp_o.err = 1'b1;
      end
   end

   assign decode_err_o = bad_err;
   assign err_adr_o    = adr_q;

   a_one_slave: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({sram_req_o.stb, ctrl_req_o.stb, ext_req_o.stb}));

endmodule

`default_nettype wire

/* rtl/wb_bus_watchdog.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_bus_watchdog (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_dbus_pkg::wb_req_t bus_req_i,
   input  wb_dbus_pkg::wb_rsp_t bus_rsp_i,
   input  logic                 wdog_en_i,
   input  logic [15:0]          wdog_limit_i,
   output logic                 wdog_abort_o
);

   logic        strobe;
   logic        strobe_d;
   logic        done;
   logic [15:0] cnt;
   logic        abort_q;

   assign strobe = bus_req_i.cyc & bus_req_i.stb;
   assign done   = bus_rsp_i.ack | bus_rsp_i.err;

   // Zero means no access being timed
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         strobe_d <= 1'b0;
         cnt      <= '0;
         abort_q  <= 1'b0;
      end else begin
         strobe_d <= strobe;
         abort_q  <= 1'b0;
         if (done || abort_q) begin
            cnt <= '0;
         end else if (strobe && !strobe_d) begin
            cnt <= 16'd1;
         end else if (cnt != 16'd0) begin
            cnt <= cnt + 16'd1;
            // Limit reached and still no answer
            if (wdog_en_i && cnt == wdog_limit_i) begin
               abort_q <= 1'b1;
            end
         end
      end
   end

   assign wdog_abort_o = abort_q;

   a_no_abort_disabled: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !wdog_en_i |=> !wdog_abort_o);

endmodule

`default_nettype wire

/* rtl/wb_bus_ctrl_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_bus_ctrl_regs (
   input  logic                             wb_clk,
   input  logic                             wb_rst,
   input  wb_dbus_pkg::wb_req_t             req_i,
   output wb_dbus_pkg::wb_rsp_t             rsp_o,
   input  logic                             decode_err_i,
   input  logic                             wdog_abort_i,
   input  logic [wb_dbus_pkg::ADR_W-1:0]    err_adr_i,
   output logic                             wdog_en_o,
   output logic [15:0]                      wdog_limit_o
);

   logic                            wdog_en_q;
   logic [15:0]                     limit_q;
   logic [15:0]                     errcnt_q;
   logic [wb_dbus_pkg::ADR_W-1:0]   lasterr_q;
   logic [wb_dbus_pkg::DAT_W-1:0]   rdat_q;
   logic                            ack_q;
   logic                            access;
   logic                            wr;
   logic                            err_event;
   logic [3:0]                      offset;

   // New strobe only, ack cycle does not count
   assign access    = req_i.cyc & req_i.stb & ~ack_q;
   assign wr        = access & req_i.we;
   assign offset    = {req_i.adr[3:2], 2'b00};
   assign err_event = decode_err_i | wdog_abort_i;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         wdog_en_q <= 1'b1;
         limit_q   <= wb_dbus_pkg::WDOG_LIMIT_RST;
         errcnt_q  <= '0;
         lasterr_q <= '0;
      end else begin
         ack_q <= access;
         if (wr && offset == wb_dbus_pkg::REG_WDOG) begin
            if (req_i.sel[3]) begin
               wdog_en_q <= req_i.dat[31];
            end
            if (req_i.sel[1]) begin
               limit_q[15:8] <= req_i.dat[15:8];
            end
            if (req_i.sel[0]) begin
               limit_q[7:0] <= req_i.dat[7:0];
            end
         end
         // Any write clears, otherwise saturating count
         if (wr && offset == wb_dbus_pkg::REG_ERRCNT) begin
            errcnt_q <= '0;
         end else if (err_event && errcnt_q != 16'hFFFF) begin
            errcnt_q <= errcnt_q + 16'd1;
         end
         if (err_event) begin
            lasterr_q <= err_adr_i;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access) begin
         case (offset)
            wb_dbus_pkg::REG_WDOG:    rdat_q <= {wdog_en_q, 15'd0, limit_q};
            wb_dbus_pkg::REG_ERRCNT:  rdat_q <= {16'd0, errcnt_q};
            wb_dbus_pkg::REG_LASTERR: rdat_q <= lasterr_q;
            default:                  rdat_q <= '0;
         endcase
      end
   end

   assign rsp_o.dat    = rdat_q;
   assign rsp_o.ack    = ack_q;
   assign rsp_o.err    = 1'b0;
   assign rsp_o.rty    = 1'b0;
   assign wdog_en_o    = wdog_en_q;
   assign wdog_limit_o = limit_q;

endmodule

`default_nettype wire

/* rtl/wb_sram_slave.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_sram_slave (
   input  logic                 wb_clk,
   input  wb_dbus_pkg::wb_req_t req_i,
   output wb_dbus_pkg::wb_rsp_t rsp_o
);

   logic [wb_dbus_pkg::DAT_W-1:0]   mem [0:(1 << wb_dbus_pkg::SRAM_AW)-1];
   logic [wb_dbus_pkg::SRAM_AW-1:0] widx;
   logic [wb_dbus_pkg::DAT_W-1:0]   rdat_q;
   logic                            ack_q;
   logic                            access;

   // Word index ignores the upper window bits
   assign widx   = req_i.adr[wb_dbus_pkg::SRAM_AW+1:2];
   assign access = req_i.cyc & req_i.stb & ~ack_q;

   // One-cycle ack per new strobe
   always_ff @(posedge wb_clk) begin
      ack_q <= access;
   end

   // Byte lane writes
   always_ff @(posedge wb_clk) begin
      for (int b = 0; b < wb_dbus_pkg::DAT_W/8; b++) begin
         if (access && req_i.we && req_i.sel[b]) begin
            mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access) begin
         rdat_q <= mem[widx];
      end
   end

   assign rsp_o.dat = rdat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.rty = 1'b0;

endmodule

`default_nettype wire

/* rtl/wb_dbus_top.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_dbus_top (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_dbus_pkg::wb_req_t cpu_req_i,
   input  wb_dbus_pkg::wb_req_t dbg_req_i,
   output wb_dbus_pkg::wb_rsp_t cpu_rsp_o,
   output wb_dbus_pkg::wb_rsp_t dbg_rsp_o,
   output wb_dbus_pkg::wb_req_t ext_req_o,
   input  wb_dbus_pkg::wb_rsp_t ext_rsp_i
);

   wb_dbus_pkg::wb_req_t            bus_req;
   wb_dbus_pkg::wb_rsp_t            bus_rsp;
   wb_dbus_pkg::wb_req_t            sram_req;
   wb_dbus_pkg::wb_rsp_t            sram_rsp;
   wb_dbus_pkg::wb_req_t            ctrl_req;
   wb_dbus_pkg::wb_rsp_t            ctrl_rsp;
   logic                            wdog_abort;
   logic                            wdog_en;
   logic [15:0]                     wdog_limit;
   logic                            decode_err;
   logic [wb_dbus_pkg::ADR_W-1:0]   err_adr;

   wb_master_arbiter u_arbiter (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .cpu_req_i (cpu_req_i),
      .dbg_req_i (dbg_req_i),
      .cpu_rsp_o (cpu_rsp_o),
      .dbg_rsp_o (dbg_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_slave_decoder u_decoder (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .bus_req_i    (bus_req),
      .bus_rsp_o    (bus_rsp),
      .sram_req_o   (sram_req),
      .ctrl_req_o   (ctrl_req),
      .ext_req_o    (ext_req_o),
      .sram_rsp_i   (sram_rsp),
      .ctrl_rsp_i   (ctrl_rsp),
      .ext_rsp_i    (ext_rsp_i),
      .wdog_abort_i (wdog_abort),
      .decode_err_o (decode_err),
      .err_adr_o    (err_adr)
   );

   wb_bus_watchdog u_watchdog (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .bus_req_i    (bus_req),
      .bus_rsp_i    (bus_rsp),
      .wdog_en_i    (wdog_en),
      .wdog_limit_i (wdog_limit),
      .wdog_abort_o (wdog_abort)
   );

   wb_bus_ctrl_regs u_ctrl_regs (
      .wb_clk       (wb_clk),
      .wb_rst       (wb_rst),
      .req_i        (ctrl_req),
      .rsp_o        (ctrl_rsp),
      .decode_err_i (decode_err),
      .wdog_abort_i (wdog_abort),
      .err_adr_i    (err_adr),
      .wdog_en_o    (wdog_en),
      .wdog_limit_o (wdog_limit)
   );

   wb_sram_slave u_sram (
      .wb_clk (wb_clk),
      .req_i  (sram_req),
      .rsp_o  (sram_rsp)
   );

endmodule

`default_nettype wire

/* tests/tb_wb_dbus.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_wb_dbus;

   localparam int TIMEOUT = 400;

   logic                 wb_clk;
   logic                 wb_rst;
   wb_dbus_pkg::wb_req_t cpu_req;
   wb_dbus_pkg::wb_req_t dbg_req;
   wb_dbus_pkg::wb_rsp_t cpu_rsp;
   wb_dbus_pkg::wb_rsp_t dbg_rsp;
   wb_dbus_pkg::wb_req_t ext_req;
   wb_dbus_pkg::wb_rsp_t ext_rsp;

   integer seed = 32'h9e06b66a;

   // External slave model
   logic [31:0] ext_mem [0:255];
   logic        never_ack;
   logic        ext_busy;
   int          ext_wait;
   int          ext_cnt;
   logic [31:0] ext_last_adr;
   logic [31:0] ext_last_dat;

   // Shadow copies of the slaves
   logic [31:0] sram_sh [0:1023];
   logic [31:0] ext_sh [0:255];
   logic        sh_en;
   logic [15:0] sh_limit;
   logic [15:0] sh_errcnt;
   logic [31:0] sh_lasterr;

   // Finished accesses waiting for the compare process
   string                q_name[$];
   wb_dbus_pkg::wb_req_t q_req[$];
   wb_dbus_pkg::wb_rsp_t q_exp[$];
   wb_dbus_pkg::wb_rsp_t q_act[$];
   int                   q_lat[$];
   int                   q_lat_exp[$];

   string cur_test;
   bit    time_chk;
   int    test_errs;
   int    n_tests;
   int    n_failed;
   int    n_errs;
   time   cpu_done_t;
   time   dbg_done_t;
   int    cpu_resp_cnt;

   wb_dbus_top DUT (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .cpu_req_i (cpu_req),
      .dbg_req_i (dbg_req),
      .cpu_rsp_o (cpu_rsp),
      .dbg_rsp_o (dbg_rsp),
      .ext_req_o (ext_req),
      .ext_rsp_i (ext_rsp)
   );

   initial wb_clk = 1'b0;
   always #5 wb_clk = ~wb_clk;

   function automatic wb_dbus_pkg::wb_req_t make_req(input logic [31:0] adr, input logic we,
                                                     input logic [31:0] dat, input logic [3:0] sel);
      wb_dbus_pkg::wb_req_t r;
      r     = '0;
      r.adr = adr;
      r.we  = we;
      r.dat = dat;
      r.sel = sel;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      return r;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdat,
                                               input logic [3:0] sel);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = wdat[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Expected response from the address map and the shadow state
   function automatic wb_dbus_pkg::wb_rsp_t ref_rsp(input wb_dbus_pkg::wb_req_t req);
      wb_dbus_pkg::wb_rsp_t rsp;
      rsp = '0;
      case (req.adr[31:28])
         wb_dbus_pkg::SRAM_BASE: begin
            rsp.ack = 1'b1;
            rsp.dat = sram_sh[req.adr[11:2]];
         end
         wb_dbus_pkg::EXT_BASE: begin
            // A stalled slave ends early only through the watchdog
            if (never_ack && sh_en) begin
               rsp.err = 1'b1;
            end else begin
               rsp.ack = 1'b1;
               rsp.dat = ext_sh[req.adr[9:2]];
            end
         end
         wb_dbus_pkg::CTRL_BASE: begin
            rsp.ack = 1'b1;
            case ({req.adr[3:2], 2'b00})
               wb_dbus_pkg::REG_WDOG:    rsp.dat = {sh_en, 15'd0, sh_limit};
               wb_dbus_pkg::REG_ERRCNT:  rsp.dat = {16'd0, sh_errcnt};
               wb_dbus_pkg::REG_LASTERR: rsp.dat = sh_lasterr;
               default:                  rsp.dat = '0;
            endcase
         end
         default: rsp.err = 1'b1;
      endcase
      return rsp;
   endfunction

   function automatic int exp_latency(input logic [31:0] adr);
      if (!time_chk || adr[31:28] == wb_dbus_pkg::EXT_BASE) begin
         return -1;
      end
      if (adr[31:28] == wb_dbus_pkg::SRAM_BASE || adr[31:28] == wb_dbus_pkg::CTRL_BASE) begin
         return 3;
      end
      return 2;
   endfunction

   function automatic void count_error(input logic [31:0] adr);
      if (sh_errcnt != 16'hFFFF) begin
         sh_errcnt = sh_errcnt + 16'd1;
      end
      sh_lasterr = adr;
   endfunction

   function automatic void update_shadow(input wb_dbus_pkg::wb_req_t req,
                                         input wb_dbus_pkg::wb_rsp_t exp);
      case (req.adr[31:28])
         wb_dbus_pkg::SRAM_BASE: begin
            if (req.we) begin
               sram_sh[req.adr[11:2]] = merge_bytes(sram_sh[req.adr[11:2]], req.dat, req.sel);
            end
         end
         wb_dbus_pkg::EXT_BASE: begin
            if (exp.err) begin
               count_error(req.adr);
            end else if (req.we) begin
               ext_sh[req.adr[9:2]] = merge_bytes(ext_sh[req.adr[9:2]], req.dat, req.sel);
            end
         end
         wb_dbus_pkg::CTRL_BASE: begin
            if (req.we && {req.adr[3:2], 2'b00} == wb_dbus_pkg::REG_WDOG) begin
               if (req.sel[3]) begin
                  sh_en = req.dat[31];
               end
               if (req.sel[1]) begin
                  sh_limit[15:8] = req.dat[15:8];
               end
               if (req.sel[0]) begin
                  sh_limit[7:0] = req.dat[7:0];
               end
            end
            if (req.we && {req.adr[3:2], 2'b00} == wb_dbus_pkg::REG_ERRCNT) begin
               sh_errcnt = '0;
            end
         end
         default: count_error(req.adr);
      endcase
   endfunction

   function automatic void record_access(input string nm, input wb_dbus_pkg::wb_req_t req,
                                         input wb_dbus_pkg::wb_rsp_t act, input int lat);
      wb_dbus_pkg::wb_rsp_t exp;
      exp = ref_rsp(req);
      update_shadow(req, exp);
      q_name.push_back(nm);
      q_req.push_back(req);
      q_exp.push_back(exp);
      q_act.push_back(act);
      q_lat.push_back(lat);
      q_lat_exp.push_back(exp_latency(req.adr));
   endfunction

   task automatic check(input string tname, input string what, input logic [31:0] exp,
                        input logic [31:0] act);
      if (exp !== act) begin
         $display("** Error: %s: %s expected %h actual %h", tname, what, exp, act);
         test_errs++;
      end
   endtask

   // Latency counts the cycles after the strobe is first seen
   task automatic cpu_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                             input logic [3:0] sel);
      wb_dbus_pkg::wb_req_t req;
      int                   lat;
      bit                   got;
      req = make_req(adr, we, dat, sel);
      lat = 0;
      got = 1'b0;
      @(negedge wb_clk);
      cpu_req = req;
      while (!got && lat < TIMEOUT) begin
         @(posedge wb_clk);
         if (cpu_rsp.ack || cpu_rsp.err) begin
            got = 1'b1;
            cpu_done_t = $time;
            cpu_resp_cnt++;
            record_access(cur_test, req, cpu_rsp, lat);
         end else begin
            lat++;
         end
      end
      if (!got) begin
         $display("%s: CPU access to %h got no response in %0d cycles", cur_test, adr, TIMEOUT);
         test_errs++;
      end
      @(negedge wb_clk);
      cpu_req = '0;
   endtask

   task automatic dbg_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                             input logic [3:0] sel);
      wb_dbus_pkg::wb_req_t req;
      int                   lat;
      bit                   got;
      req = make_req(adr, we, dat, sel);
      lat = 0;
      got = 1'b0;
      @(negedge wb_clk);
      dbg_req = req;
      while (!got && lat < TIMEOUT) begin
         @(posedge wb_clk);
         if (dbg_rsp.ack || dbg_rsp.err) begin
            got = 1'b1;
            dbg_done_t = $time;
            record_access(cur_test, req, dbg_rsp, lat);
         end else begin
            lat++;
         end
      end
      if (!got) begin
         $display("%s: debug access to %h got no response in %0d cycles", cur_test, adr, TIMEOUT);
         test_errs++;
      end
      @(negedge wb_clk);
      dbg_req = '0;
   endtask

   // External slave model with 0 to 5 wait states per access
   always @(negedge wb_clk) begin
      if (wb_rst) begin
         ext_rsp  = '0;
         ext_busy = 1'b0;
      end else if (ext_rsp.ack) begin
         ext_rsp.ack = 1'b0;
      end else if (ext_req.cyc && ext_req.stb) begin
         if (!ext_busy) begin
            ext_busy = 1'b1;
            ext_cnt  = 0;
            ext_wait = $unsigned($random(seed)) % 6;
         end
         if (!never_ack && ext_cnt >= ext_wait) begin
            ext_last_adr = ext_req.adr;
            ext_last_dat = ext_req.dat;
            if (ext_req.we) begin
               ext_mem[ext_req.adr[9:2]] = merge_bytes(ext_mem[ext_req.adr[9:2]], ext_req.dat,
                                                       ext_req.sel);
            end
            ext_rsp.dat = ext_mem[ext_req.adr[9:2]];
            ext_rsp.ack = 1'b1;
            ext_busy    = 1'b0;
         end else begin
            ext_cnt++;
         end
      end else begin
         // Strobe withdrawn by a watchdog abort
         ext_busy = 1'b0;
      end
   end

   always @(negedge wb_clk) begin : compare_proc
      string                nm;
      wb_dbus_pkg::wb_req_t req;
      wb_dbus_pkg::wb_rsp_t exp;
      wb_dbus_pkg::wb_rsp_t act;
      int                   lat;
      int                   lat_exp;
      while (q_exp.size() != 0) begin
         nm      = q_name.pop_front();
         req     = q_req.pop_front();
         exp     = q_exp.pop_front();
         act     = q_act.pop_front();
         lat     = q_lat.pop_front();
         lat_exp = q_lat_exp.pop_front();
         check(nm, "ack", exp.ack, act.ack);
         check(nm, "err", exp.err, act.err);
         check(nm, "rty", exp.rty, act.rty);
         if (exp.ack && !req.we) begin
            check(nm, "read data", exp.dat, act.dat);
         end
         if (lat_exp >= 0) begin
            check(nm, "latency", lat_exp, lat);
         end
      end
   end

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      int n;
      n = 0;
      while (q_exp.size() != 0 && n < 10) begin
         @(negedge wb_clk);
         n++;
      end
      if (q_exp.size() != 0) begin
         $display("%s: responses were left uncompared", cur_test);
         test_errs++;
      end
      if (test_errs == 0) begin
         $display("%s: ok", cur_test);
      end else begin
         $display("%s: FAILED with %0d errors", cur_test, test_errs);
         n_failed++;
      end
      n_tests++;
      n_errs += test_errs;
   endtask

   initial begin : main_seq
      logic [31:0] d;
      logic [31:0] adr;
      int          n0;
      cpu_req      = '0;
      dbg_req      = '0;
      ext_rsp      = '0;
      wb_rst       = 1'b1;
      never_ack    = 1'b0;
      ext_busy     = 1'b0;
      ext_wait     = 0;
      ext_cnt      = 0;
      time_chk     = 1'b1;
      n_tests      = 0;
      n_failed     = 0;
      n_errs       = 0;
      cpu_resp_cnt = 0;
      sh_en        = 1'b1;
      sh_limit     = 16'd64;
      sh_errcnt    = '0;
      sh_lasterr   = '0;
      for (int i = 0; i < 256; i++) begin
         ext_mem[i] = '0;
         ext_sh[i]  = '0;
      end
      repeat (5) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      start_test("reset_values");
      cpu_access(32'hF000_0000, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0004, 1'b0, '0, 4'hF);
      end_test();

      // Full word write followed by one partial lane pattern per word
      start_test("sram_byte_lanes");
      for (int i = 0; i < 8; i++) begin
         adr = 32'h0000_0100 + 4 * i;
         cpu_access(adr, 1'b1, $random(seed), 4'hF);
         cpu_access(adr, 1'b1, $random(seed), 4'(i + 1));
         cpu_access(adr, 1'b0, '0, 4'hF);
      end
      dbg_access(32'h0AB0_1104, 1'b0, '0, 4'hF);
      end_test();

      start_test("ext_window");
      for (int i = 0; i < 6; i++) begin
         adr = 32'h9000_0040 + 4 * i;
         d   = $random(seed);
         cpu_access(adr, 1'b1, d, 4'hF);
         check(cur_test, "ext write address", adr, ext_last_adr);
         check(cur_test, "ext write data", d, ext_last_dat);
         ext_last_adr = 'x;
         dbg_access(adr, 1'b0, '0, 4'hF);
         check(cur_test, "ext read address", adr, ext_last_adr);
      end
      end_test();

      start_test("unmapped");
      cpu_access(32'h5000_0000, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0004, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0008, 1'b0, '0, 4'hF);
      dbg_access(32'h7000_0010, 1'b1, 32'h1234_5678, 4'hF);
      cpu_access(32'hF000_0004, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0008, 1'b0, '0, 4'hF);
      end_test();

      start_test("arbitration");
      time_chk = 1'b0;
      fork
         cpu_access(32'h0000_0200, 1'b1, 32'hC0C0_0001, 4'hF);
         dbg_access(32'h0000_0204, 1'b1, 32'hDB00_0002, 4'hF);
      join
      check(cur_test, "debug done first", 1, dbg_done_t < cpu_done_t);
      never_ack = 1'b1;
      fork
         cpu_access(32'h9000_0080, 1'b0, '0, 4'hF);
         begin
            repeat (3) @(negedge wb_clk);
            dbg_access(32'h0000_0200, 1'b0, '0, 4'hF);
         end
         begin
            repeat (10) @(posedge wb_clk);
            never_ack = 1'b0;
         end
      join
      check(cur_test, "cpu done first", 1, cpu_done_t < dbg_done_t);
      time_chk = 1'b1;
      end_test();

      start_test("watchdog");
      cpu_access(32'hF000_0000, 1'b1, 32'h8000_000A, 4'hF);
      never_ack = 1'b1;
      cpu_access(32'h9000_00C0, 1'b0, '0, 4'hF);
      never_ack = 1'b0;
      cpu_access(32'hF000_0004, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0008, 1'b0, '0, 4'hF);
      // Disabled watchdog lets the stalled access hang
      cpu_access(32'hF000_0000, 1'b1, 32'h0000_000A, 4'hF);
      never_ack = 1'b1;
      n0 = cpu_resp_cnt;
      fork
         cpu_access(32'h9000_00C4, 1'b0, '0, 4'hF);
         begin
            repeat (100) @(posedge wb_clk);
            check(cur_test, "responses while stalled", n0, cpu_resp_cnt);
            never_ack = 1'b0;
         end
      join
      cpu_access(32'hF000_0000, 1'b1, 32'h8000_0040, 4'hF);
      cpu_access(32'hF000_0000, 1'b0, '0, 4'hF);
      cpu_access(32'hF000_0004, 1'b1, '0, 4'hF);
      cpu_access(32'hF000_0004, 1'b0, '0, 4'hF);
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, n_errs);
      if (n_failed == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
rtl/wb_dbus_pkg.sv
rtl/wb_master_arbiter.sv
rtl/wb_slave_decoder.sv
rtl/wb_bus_watchdog.sv
rtl/wb_bus_ctrl_regs.sv
rtl/wb_sram_slave.sv
rtl/wb_dbus_top.sv
tests/tb_wb_dbus.sv
